// File: hw/hps_io_pkg.sv
package hps_io_pkg;

	////////////////////////////////////////
	// bus and field widths
	////////////////////////////////////////

	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;
	// saturates at its top value
	typedef logic [5:0]  word_cnt_t;
	typedef logic [15:0] cmd_t;
	typedef logic [31:0] joystick_t;
	typedef logic [63:0] status_t;
	// [7:0] code, [8] extended, [9] pressed, [10] event toggle
	typedef logic [10:0] ps2_key_t;
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [31:0] file_ext_t;

	////////////////////////////////////////
	// command codes
	////////////////////////////////////////

	localparam cmd_t CMD_CFG         = 16'h0001;
	localparam cmd_t CMD_JOY0        = 16'h0002;
	localparam cmd_t CMD_JOY1        = 16'h0003;
	localparam cmd_t CMD_PS2_KBD     = 16'h0005;
	localparam cmd_t CMD_CONF_STR    = 16'h0014;
	localparam cmd_t CMD_STATUS      = 16'h001E;
	localparam cmd_t FIO_FILE_TX     = 16'h0053;
	localparam cmd_t FIO_FILE_TX_DAT = 16'h0054;
	localparam cmd_t FIO_FILE_INDEX  = 16'h0055;
	localparam cmd_t FIO_FILE_INFO   = 16'h0056;

	// keyboard bytes and special sequences
	localparam byte_t PS2_SKIP_MARK = 8'hFF;
	localparam byte_t KEY_EXT_PREFIX = 8'hE0;
	localparam byte_t KEY_BREAK_PREFIX = 8'hF0;
	localparam logic [31:0] KEY_PRNSCR_PRESS_RAW   = 32'hE012E07C;
	localparam logic [31:0] KEY_PRNSCR_RELEASE_RAW = 32'h7CE0F012;
	localparam logic [31:0] KEY_PAUSE_RAW          = 32'hF014F077;
	localparam logic [9:0] KEY_PRNSCR_PRESS_CODE   = 10'h37C;
	localparam logic [9:0] KEY_PRNSCR_RELEASE_CODE = 10'h17C;
	localparam logic [9:0] KEY_PAUSE_CODE          = 10'h377;

	// menu string, first character in the top byte
	localparam int CONF_STR_LEN = 12;
	localparam logic [8*CONF_STR_LEN-1:0] CONF_STR = "DEMO;;V,v1.0";

	// one data word of a user-I/O frame
	typedef struct packed {
		logic      valid;
		cmd_t      cmd;
		word_cnt_t idx;
		word_t     data;
	} uio_word_s;

	// end-of-frame pulse
	typedef struct packed {
		logic valid;
		cmd_t cmd;
	} uio_end_s;

endpackage

// File: hw/uio_cmd_frame.sv
`timescale 1ns/1ps

module uio_cmd_frame (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_enable,
	input  logic                  io_strobe,
	input  hps_io_pkg::word_t     io_din,
	output hps_io_pkg::uio_word_s word,
	output hps_io_pkg::uio_end_s  frame_end
);
	import hps_io_pkg::*;

	cmd_t      cmd;
	word_cnt_t cnt;
	logic      in_frame;

	// cnt is 0 for the command word, then the data index
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd      <= '0;
			cnt      <= '0;
			in_frame <= 1'b0;
		end else begin
			in_frame <= io_enable;
			if (!io_enable) begin
				cmd <= '0;
				cnt <= '0;
			end else if (io_strobe) begin
				if (cnt == '0)
					cmd <= io_din;
				if (!(&cnt))
					cnt <= cnt + 1'b1;
			end
		end
	end

	// data word, valid in the strobe cycle itself
	always_comb begin
		word.valid = io_enable && io_strobe && (cnt != '0);
		word.cmd   = cmd;
		word.idx   = cnt;
		word.data  = io_din;
	end

	// first low-enable cycle after a frame
	always_comb begin
		frame_end.valid = in_frame && !io_enable;
		frame_end.cmd   = cmd;
	end

endmodule

// File: hw/uio_input_regs.sv
`timescale 1ns/1ps

module uio_input_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  hps_io_pkg::uio_word_s word,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output logic                  direct_video,
	output hps_io_pkg::joystick_t joystick_0,
	output hps_io_pkg::joystick_t joystick_1,
	output hps_io_pkg::status_t   status
);
	import hps_io_pkg::*;

	word_t cfg;

	// other cfg bits belong to the system side
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	////////////////////////////////////////
	// host writes
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (word.valid) begin
			case (word.cmd)
				CMD_CFG: begin
					cfg <= word.data;
				end
				// index 1 is the low half, later words the high half
				CMD_JOY0: begin
					if (word.idx == 6'd1)
						joystick_0[15:0] <= word.data;
					else
						joystick_0[31:16] <= word.data;
				end
				CMD_JOY1: begin
					if (word.idx == 6'd1)
						joystick_1[15:0] <= word.data;
					else
						joystick_1[31:16] <= word.data;
				end
				CMD_STATUS: begin
					case (word.idx)
						6'd1: status[15:0]  <= word.data;
						6'd2: status[31:16] <= word.data;
						6'd3: status[47:32] <= word.data;
						6'd4: status[63:48] <= word.data;
						// extra words dropped
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hw/ps2_key_decoder.sv
`timescale 1ns/1ps

module ps2_key_decoder (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  hps_io_pkg::uio_word_s word,
	input  hps_io_pkg::uio_end_s  frame_end,
	output hps_io_pkg::ps2_key_t  ps2_key
);
	import hps_io_pkg::*;

	logic [31:0] key_raw;
	logic        skip;
	logic        kbd_word;
	logic        mark;
	logic        pressed;
	logic        extended;

	assign kbd_word = word.valid && (word.cmd == CMD_PS2_KBD);
	assign mark     = (word.data[15:8] == PS2_SKIP_MARK);

	// release has F0 before the code, E0 one byte further back
	assign pressed  = (key_raw[15:8] != KEY_BREAK_PREFIX);
	assign extended = pressed ? (key_raw[15:8] == KEY_EXT_PREFIX) :
		(key_raw[23:16] == KEY_EXT_PREFIX);

	////////////////////////////////////////
	// byte collection
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_raw <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (kbd_word && word.idx == 6'd1) begin
				// new frame, drop the old bytes
				skip    <= mark;
				key_raw <= mark ? 32'h0 : {24'h0, word.data[7:0]};
			end else if (kbd_word) begin
				if (mark)
					skip <= 1'b1;
				else if (!skip)
					key_raw <= {key_raw[23:0], word.data[7:0]};
			end

			if (frame_end.valid && frame_end.cmd == CMD_PS2_KBD && !skip) begin
				ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
				if (key_raw == KEY_PRNSCR_PRESS_RAW)
					ps2_key[9:0] <= KEY_PRNSCR_PRESS_CODE;
				if (key_raw == KEY_PRNSCR_RELEASE_RAW)
					ps2_key[9:0] <= KEY_PRNSCR_RELEASE_CODE;
				if (key_raw == KEY_PAUSE_RAW)
					ps2_key[9:0] <= KEY_PAUSE_CODE;
			end
			if (frame_end.valid)
				skip <= 1'b0;
		end
	end

endmodule

// File: hw/conf_string_reader.sv
`timescale 1ns/1ps

module conf_string_reader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_enable,
	input  hps_io_pkg::uio_word_s word,
	output hps_io_pkg::word_t     io_dout
);
	import hps_io_pkg::*;

	byte_t conf_byte;

	// byte n of the string, counted from 1
	always_comb begin
		conf_byte = '0;
		if (word.idx != '0 && int'(word.idx) <= CONF_STR_LEN)
			conf_byte = CONF_STR[(CONF_STR_LEN - int'(word.idx)) * 8 +: 8];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_dout <= '0;
		end else if (!io_enable) begin
			io_dout <= '0;
		end else if (word.valid) begin
			if (word.cmd == CMD_CONF_STR)
				io_dout <= {8'h00, conf_byte};
			else
				io_dout <= '0;
		end
	end

endmodule

// File: hw/file_download.sv
`timescale 1ns/1ps

module file_download (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    fp_enable,
	input  logic                    io_strobe,
	input  hps_io_pkg::word_t       io_din,
	output logic                    ioctl_download,
	output hps_io_pkg::word_t       ioctl_index,
	output hps_io_pkg::file_ext_t   ioctl_file_ext,
	output logic                    ioctl_wr,
	output hps_io_pkg::ioctl_addr_t ioctl_addr,
	output hps_io_pkg::byte_t       ioctl_dout
);
	import hps_io_pkg::*;

	cmd_t        cmd;
	word_cnt_t   cnt;
	ioctl_addr_t addr;
	logic        data_strobe;

	// any strobe after the command word
	assign data_strobe = fp_enable && io_strobe && (cnt != '0);

	////////////////////////////////////////
	// frame tracking
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd <= '0;
			cnt <= '0;
		end else if (!fp_enable) begin
			cnt <= '0;
		end else if (io_strobe) begin
			if (cnt == '0)
				cmd <= io_din;
			if (!(&cnt))
				cnt <= cnt + 1'b1;
		end
	end

	// download control and write pulse
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
		end else begin
			ioctl_wr <= 1'b0;
			if (data_strobe && cmd == FIO_FILE_TX && cnt == 6'd1) begin
				if (io_din[7:0] != 8'h00)
					ioctl_download <= 1'b1;
				else if (io_din == '0)
					ioctl_download <= 1'b0;
			end
			if (data_strobe && cmd == FIO_FILE_TX_DAT && ioctl_download)
				ioctl_wr <= 1'b1;
		end
	end

	////////////////////////////////////////
	// payload
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (data_strobe) begin
			case (cmd)
				FIO_FILE_TX: begin
					if (cnt == 6'd1 && io_din[7:0] != 8'h00)
						addr <= '0;
				end
				FIO_FILE_TX_DAT: begin
					if (ioctl_download) begin
						ioctl_addr <= addr;
						ioctl_dout <= io_din[7:0];
						addr       <= addr + 1'b1;
					end
				end
				FIO_FILE_INDEX: begin
					ioctl_index <= io_din;
				end
				// extension comes high half first
				FIO_FILE_INFO: begin
					if (cnt == 6'd1)
						ioctl_file_ext[31:16] <= io_din;
					else if (cnt == 6'd2)
						ioctl_file_ext[15:0] <= io_din;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hw/hps_io_top.sv
`timescale 1ns/1ps

module hps_io_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      io_strobe,
	input  logic                      io_enable,
	input  logic                      fp_enable,
	input  hps_io_pkg::word_t         io_din,
	output hps_io_pkg::word_t         io_dout,
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output logic                      direct_video,
	output hps_io_pkg::joystick_t     joystick_0,
	output hps_io_pkg::joystick_t     joystick_1,
	output hps_io_pkg::status_t       status,
	output hps_io_pkg::ps2_key_t      ps2_key,
	output logic                      ioctl_download,
	output hps_io_pkg::word_t         ioctl_index,
	output hps_io_pkg::file_ext_t     ioctl_file_ext,
	output logic                      ioctl_wr,
	output hps_io_pkg::ioctl_addr_t   ioctl_addr,
	output hps_io_pkg::byte_t         ioctl_dout
);
	import hps_io_pkg::*;

	uio_word_s uio_word;
	uio_end_s  uio_end;

	////////////////////////////////////////
	// user-I/O side
	////////////////////////////////////////

	uio_cmd_frame u_cmd_frame (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word      (uio_word),
		.frame_end (uio_end)
	);

	uio_input_regs u_input_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.word               (uio_word),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	ps2_key_decoder u_key_decoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.word      (uio_word),
		.frame_end (uio_end),
		.ps2_key   (ps2_key)
	);

	conf_string_reader u_conf_reader (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.word      (uio_word),
		.io_dout   (io_dout)
	);

	// file transfers run on their own frames
	file_download u_download (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// File: tb/tb_hps_io_tasks.svh
////////////////////////////////////////
// frame driving
////////////////////////////////////////

// command word first, then one data word per cycle
task automatic drive_frame(input logic fio, input cmd_t cmd, input word_t words[$]);
	int i;
	dout_q.delete();
	@(negedge clk_sys);
	if (fio)
		fp_enable = 1'b1;
	else
		io_enable = 1'b1;
	io_strobe = 1'b1;
	io_din    = cmd;
	for (i = 0; i < words.size(); i++) begin
		@(negedge clk_sys);
		if (i > 0)
			dout_q.push_back(io_dout);
		io_din = words[i];
	end
	@(negedge clk_sys);
	if (words.size() > 0)
		dout_q.push_back(io_dout);
	io_strobe = 1'b0;
	io_enable = 1'b0;
	fp_enable = 1'b0;
	io_din    = '0;
endtask

task automatic send_uio_frame(input cmd_t cmd, input word_t words[$]);
	drive_frame(1'b0, cmd, words);
endtask

task automatic send_fio_frame(input cmd_t cmd, input word_t words[$]);
	drive_frame(1'b1, cmd, words);
endtask

////////////////////////////////////////
// compares
////////////////////////////////////////

task automatic check_joystick(input string name, input joystick_t exp, input joystick_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_status(input string name, input status_t exp, input status_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_key(input string name, input ps2_key_t exp, input ps2_key_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_addr(input string name, input ioctl_addr_t exp, input ioctl_addr_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_ext(input string name, input file_ext_t exp, input file_ext_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("mismatch %s: expected %b, actual %b", name, exp, act);
	end
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic joystick_and_cfg_test();
	word_t j0[$];
	word_t j1[$];
	word_t cfg[$];
	int i;
	j0.push_back(word_t'($random(seed)));
	j0.push_back(word_t'($random(seed)));
	j1.push_back(word_t'($random(seed)));
	j1.push_back(word_t'($random(seed)));
	// bit 4 set and bit 10 clear, the second frame inverts both
	cfg.push_back((word_t'($random(seed)) | 16'h0010) & ~16'h0400);
	send_uio_frame(CMD_JOY0, j0);
	send_uio_frame(CMD_JOY1, j1);
	// high word joined with low word
	check_joystick("joystick joystick_0", {j0[1], j0[0]}, joystick_0);
	check_joystick("joystick joystick_1", {j1[1], j1[0]}, joystick_1);
	for (i = 0; i < 2; i++) begin
		if (i == 1)
			cfg[0] = ~cfg[0];
		send_uio_frame(CMD_CFG, cfg);
		check_word($sformatf("cfg buttons %0d", i), word_t'(cfg[0][1:0]),
			word_t'(buttons));
		check_bit($sformatf("cfg forced_scandoubler %0d", i), cfg[0][4],
			forced_scandoubler);
		check_bit($sformatf("cfg direct_video %0d", i), cfg[0][10], direct_video);
	end
endtask

task automatic status_word_test();
	word_t w[$];
	int i;
	for (i = 0; i < 5; i++)
		w.push_back(word_t'($random(seed)));
	send_uio_frame(CMD_STATUS, w);
	// fifth word must not land anywhere
	check_status("status", {w[3], w[2], w[1], w[0]}, status);
endtask

task automatic conf_string_test();
	word_t w[$];
	word_t exp;
	logic [8*CONF_STR_LEN-1:0] text;
	int n;
	for (n = 0; n < CONF_STR_LEN + 2; n++)
		w.push_back('0);
	send_uio_frame(CMD_CONF_STR, w);
	text = CONF_STR;
	for (n = 1; n <= dout_q.size(); n++) begin
		exp = '0;
		// characters leave from the top byte
		if (n <= CONF_STR_LEN) begin
			exp  = {8'h00, text[8*CONF_STR_LEN-1 -: 8]};
			text = text << 8;
		end
		check_word($sformatf("conf string byte %0d", n), exp, dout_q[n - 1]);
	end
	// short frame leaves a non-zero byte behind
	w.delete();
	w.push_back('0);
	send_uio_frame(CMD_CONF_STR, w);
	@(negedge clk_sys);
	check_word("conf string after frame", '0, io_dout);
endtask

// sends the low count bytes of raw, oldest byte first
task automatic send_key_bytes(input logic [31:0] raw, input int count);
	word_t w[$];
	int i;
	for (i = count - 1; i >= 0; i--)
		w.push_back({8'h00, raw[i * 8 +: 8]});
	send_uio_frame(CMD_PS2_KBD, w);
	@(negedge clk_sys);
endtask

task automatic keyboard_event_test();
	word_t w[$];
	logic tgl;
	ps2_key_t exp;
	tgl = 1'b0;
	send_key_bytes(32'h0000001C, 1);
	tgl = ~tgl;
	exp = {tgl, 1'b1, 1'b0, 8'h1C};
	check_key("keyboard plain press", exp, ps2_key);
	send_key_bytes(32'h00E0F075, 3);
	tgl = ~tgl;
	exp = {tgl, 1'b0, 1'b1, 8'h75};
	check_key("keyboard extended release", exp, ps2_key);
	send_key_bytes(KEY_PRNSCR_PRESS_RAW, 4);
	tgl = ~tgl;
	exp = {tgl, 10'h37C};
	check_key("keyboard print screen", exp, ps2_key);
	// plain rule would give 077 here
	send_key_bytes(KEY_PAUSE_RAW, 4);
	tgl = ~tgl;
	exp = {tgl, 10'h377};
	check_key("keyboard pause", exp, ps2_key);
	// skip mark in the first word hides the whole frame
	w.push_back({PS2_SKIP_MARK, 8'h1C});
	w.push_back(16'h002A);
	send_uio_frame(CMD_PS2_KBD, w);
	@(negedge clk_sys);
	check_key("keyboard skipped frame", exp, ps2_key);
endtask

// one byte per cycle with ioctl_wr high
task automatic collect_writes(input word_t data[$]);
	int k;
	int t;
	for (k = 0; k < data.size(); k++) begin
		t = 0;
		@(negedge clk_sys);
		while (!ioctl_wr && t < 64) begin
			@(negedge clk_sys);
			t++;
		end
		if (!ioctl_wr) begin
			errors++;
			$display("download: no ioctl_wr for byte %0d within 64 cycles", k);
			return;
		end
		check_addr($sformatf("download addr %0d", k), ioctl_addr_t'(k), ioctl_addr);
		check_word($sformatf("download byte %0d", k), {8'h00, data[k][7:0]},
			{8'h00, ioctl_dout});
	end
endtask

task automatic file_download_test();
	word_t idx[$];
	word_t info[$];
	word_t ctl[$];
	word_t data[$];
	int i;
	idx.push_back(word_t'($random(seed)));
	info.push_back(word_t'($random(seed)));
	info.push_back(word_t'($random(seed)));
	for (i = 0; i < 8; i++)
		data.push_back(word_t'($random(seed)));
	send_fio_frame(FIO_FILE_INDEX, idx);
	send_fio_frame(FIO_FILE_INFO, info);
	check_word("download index", idx[0], ioctl_index);
	check_ext("download extension", {info[0], info[1]}, ioctl_file_ext);
	ctl.push_back(16'h0001);
	send_fio_frame(FIO_FILE_TX, ctl);
	check_bit("download start", 1'b1, ioctl_download);
	fork
		send_fio_frame(FIO_FILE_TX_DAT, data);
		collect_writes(data);
	join
	check_bit("download during data", 1'b1, ioctl_download);
	ctl[0] = 16'h0000;
	send_fio_frame(FIO_FILE_TX, ctl);
	check_bit("download end", 1'b0, ioctl_download);
endtask

// File: tb/tb_hps_io.sv
`timescale 1ns/1ps

module tb_hps_io;
	import hps_io_pkg::*;

	logic        clk_sys;
	logic        reset;
	logic        io_strobe;
	logic        io_enable;
	logic        fp_enable;
	word_t       io_din;
	word_t       io_dout;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	joystick_t   joystick_0;
	joystick_t   joystick_1;
	status_t     status;
	ps2_key_t    ps2_key;
	logic        ioctl_download;
	word_t       ioctl_index;
	file_ext_t   ioctl_file_ext;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	byte_t       ioctl_dout;

	integer seed;
	int     errors;
	int     checks;
	// io_dout seen after each data strobe of the last frame
	word_t  dout_q[$];

	hps_io_top u_dut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	// 40 ns period
	always #20 clk_sys = ~clk_sys;

	`include "tb_hps_io_tasks.svh"

	initial begin
		clk_sys   = 1'b0;
		reset     = 1'b1;
		io_strobe = 1'b0;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_din    = '0;
		seed      = 32'h3401;
		errors    = 0;
		checks    = 0;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		joystick_and_cfg_test();
		status_word_test();
		conf_string_test();
		keyboard_event_test();
		file_download_test();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: compile.f
+incdir+tb
hw/hps_io_pkg.sv
hw/uio_cmd_frame.sv
hw/uio_input_regs.sv
hw/ps2_key_decoder.sv
hw/conf_string_reader.sv
hw/file_download.sv
hw/hps_io_top.sv
tb/tb_hps_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f compile.f --top-module tb_hps_io -Mdir obj_dir -o tb_hps_io
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_hps_io > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
	echo "simulation result: passed"
	exit 0
else
	echo "simulation result: failed"
	exit 1
fi
